/* vlog.f */
src/vid_fabric_pkg.sv
src/regbus_if.sv
src/lane_ram.sv
src/regbus_decoder.sv
src/membus_arbiter.sv
src/palette_bank.sv
src/vid_fabric_top.sv
dv/vid_fabric_chk.sv
dv/tb_vid_fabric.sv

/* Makefile */
# Verilator build and run for the video bus fabric testbench

VERILATOR  ?= verilator
TOP        ?= tb_vid_fabric
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j $(JOBS)
PASS_MSG   ?= ** PASS **

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the run prints the pass message
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* dv/vid_fabric_testdata.txt */
// test  op  address  data  expected, all hex
// op 0 write, 1 read-expect, 2 fetch-expect, 3 display-expect, 4 fetch-under-load, 5 reset
1 5 00000 00 00
2 0 00010 a5 00
2 0 00013 3c 00
2 0 1ffff 77 00
2 1 00010 00 a5
2 1 00013 00 3c
2 1 1ffff 00 77
2 0 20010 99 00
2 1 20010 00 00
2 1 00010 00 a5
2 1 f2004 00 00
2 1 f0000 00 00
3 0 00100 11 00
3 0 00101 22 00
3 0 00102 33 00
3 0 00103 44 00
3 2 00040 00 44332211
3 0 1fffc de 00
3 0 1fffd ad 00
3 0 1fffe be 00
3 0 1ffff ef 00
3 2 07fff 00 efbeadde
4 4 00040 00100 44332211
5 0 f1010 34 00
5 0 f1011 12 00
5 0 f11fe cd 00
5 0 f11ff ab 00
5 0 f1000 0f 00
5 0 f1001 f5 00
5 1 f1010 00 34
5 1 f1011 00 12
5 1 f11fe 00 cd
5 1 f11ff 00 ab
6 3 00008 00 234
6 3 000ff 00 bcd
6 3 00000 00 50f

/* dv/tb_vid_fabric.sv */
`timescale 1ns/1ps

module tb_vid_fabric;

    localparam int CLK_PERIOD     = 8;
    localparam int FIELDS         = 5;
    localparam int MAX_RECORDS    = 64;
    localparam int CYCLES_PER_REC = 40;
    localparam int ACK_LIMIT      = 16;
    localparam int AW             = vid_fabric_pkg::REG_ADDR_W;
    localparam int BW             = vid_fabric_pkg::BYTE_W;
    localparam int FW             = vid_fabric_pkg::FETCH_ADDR_W;

    // Operation codes of the data file
    localparam logic [31:0] OP_WRITE      = 32'd0;
    localparam logic [31:0] OP_READ       = 32'd1;
    localparam logic [31:0] OP_FETCH      = 32'd2;
    localparam logic [31:0] OP_DISPLAY    = 32'd3;
    localparam logic [31:0] OP_FETCH_LOAD = 32'd4;
    localparam logic [31:0] OP_RESET      = 32'd5;

    logic                      clk;
    logic                      reset;
    vid_fabric_pkg::reg_addr_t reg_addr;
    logic [BW-1:0]             reg_wrdata;
    logic                      reg_strobe;
    logic                      reg_write;
    logic [BW-1:0]             reg_rddata;
    logic [FW-1:0]             fetch_addr;
    logic                      fetch_strobe;
    logic                      fetch_ack;
    vid_fabric_pkg::mem_word_t fetch_rddata;
    logic [BW-1:0]             display_idx;
    vid_fabric_pkg::rgb_t      display_rgb;

    logic [31:0] records [MAX_RECORDS*FIELDS];
    int          num_records;
    logic        records_loaded;
    int          seed;
    int          error_count;
    int          check_count;
    int          test_count;
    int          test_checks;
    int          test_errors;

    vid_fabric_top i_dut (
        .clk            (clk),
        .reset          (reset),
        .reg_addr_i     (reg_addr),
        .reg_wrdata_i   (reg_wrdata),
        .reg_strobe_i   (reg_strobe),
        .reg_write_i    (reg_write),
        .reg_rddata_o   (reg_rddata),
        .fetch_addr_i   (fetch_addr),
        .fetch_strobe_i (fetch_strobe),
        .fetch_ack_o    (fetch_ack),
        .fetch_rddata_o (fetch_rddata),
        .display_idx_i  (display_idx),
        .display_rgb_o  (display_rgb)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Checking and reporting
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        test_checks++;
        assert (actual === expected) else begin
            $display("MISMATCH time %0t: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        test_errors++;
        $display("ERROR time %0t: %s", $time, what);
    endtask

    task automatic close_test(input logic [31:0] test_no);
        $display("test %0d done: %0d checks, %0d errors", test_no, test_checks, test_errors);
        test_count++;
        test_checks = 0;
        test_errors = 0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus drivers start and end on a falling edge
    ////////////////////////////////////////////////////////////////////////////
    task automatic apply_reset();
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    // Reset pulse with a fetch and a palette read left pending across it
    task automatic reset_while_busy(input logic [31:0] addr);
        fetch_addr   = addr[FW-1:0];
        fetch_strobe = 1'b1;
        reg_addr     = {vid_fabric_pkg::REG_PAGE_HI, vid_fabric_pkg::PAGE_PALETTE, addr[11:0]};
        reg_write    = 1'b0;
        reg_strobe   = 1'b1;
        apply_reset();
        fetch_strobe = 1'b0;
        reg_strobe   = 1'b0;
    endtask

    task automatic reg_access(input logic [31:0] addr, input logic [31:0] data,
                              input logic wr);
        reg_addr   = addr[AW-1:0];
        reg_wrdata = data[BW-1:0];
        reg_write  = wr;
        reg_strobe = 1'b1;
        @(negedge clk);
        reg_strobe = 1'b0;
        reg_write  = 1'b0;
    endtask

    task automatic wait_for_ack(output logic got_ack);
        int waited;
        got_ack = 1'b0;
        waited  = 0;
        while (!got_ack && waited < ACK_LIMIT) begin
            @(negedge clk);
            got_ack = fetch_ack;
            waited++;
        end
    endtask

    // One ack with the word and no second ack once strobe drops
    task automatic finish_fetch(input logic [31:0] expected);
        logic got_ack;
        wait_for_ack(got_ack);
        assert (got_ack) else report_failure("fetch_ack_o never rose for a pending fetch");
        if (got_ack) begin
            check_value("fetch_rddata_o", expected, fetch_rddata);
        end
        fetch_strobe = 1'b0;
        @(negedge clk);
        check_value("fetch_ack_o", 32'h0, {31'h0, fetch_ack});
    endtask

    task automatic fetch_word(input logic [31:0] addr, input logic [31:0] expected);
        fetch_addr   = addr[FW-1:0];
        fetch_strobe = 1'b1;
        finish_fetch(expected);
    endtask

    // Back-to-back register reads hold off a pending fetch
    task automatic fetch_under_load(input logic [31:0] addr, input logic [31:0] base,
                                    input logic [31:0] expected);
        int n;
        n = 2 + ({$random(seed)} % 6);
        fetch_addr   = addr[FW-1:0];
        fetch_strobe = 1'b1;
        reg_write    = 1'b0;
        reg_strobe   = 1'b1;
        for (int i = 0; i < n; i++) begin
            reg_addr = {base[AW-1:2], 2'(i)};
            @(negedge clk);
            check_value("fetch_ack_o", 32'h0, {31'h0, fetch_ack});
        end
        reg_strobe = 1'b0;
        finish_fetch(expected);
    endtask

    task automatic display_lookup(input logic [31:0] idx, input logic [31:0] expected);
        display_idx = idx[BW-1:0];
        @(negedge clk);
        check_value("display_rgb_o", expected, {20'h0, display_rgb});
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] test_no;
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expected;
        logic [31:0] current_test;
        clk            = 1'b0;
        reset          = 1'b1;
        reg_addr       = '0;
        reg_wrdata     = '0;
        reg_strobe     = 1'b0;
        reg_write      = 1'b0;
        fetch_addr     = '0;
        fetch_strobe   = 1'b0;
        display_idx    = '0;
        seed           = 17;
        error_count    = 0;
        check_count    = 0;
        test_count     = 0;
        test_checks    = 0;
        test_errors    = 0;
        num_records    = 0;
        records_loaded = 1'b0;

        // All-ones test number marks the end of the records
        for (int i = 0; i < MAX_RECORDS*FIELDS; i++) begin
            records[i] = '1;
        end
        $readmemh("dv/vid_fabric_testdata.txt", records);
        while (num_records < MAX_RECORDS && records[num_records*FIELDS] !== '1) begin
            num_records++;
        end
        records_loaded = 1'b1;
        assert (num_records > 0) else report_failure("no test records read from the data file");

        apply_reset();
        current_test = records[0];
        for (int r = 0; r < num_records; r++) begin
            test_no  = records[r*FIELDS];
            op       = records[r*FIELDS+1];
            addr     = records[r*FIELDS+2];
            data     = records[r*FIELDS+3];
            expected = records[r*FIELDS+4];
            if (test_no != current_test) begin
                close_test(current_test);
                current_test = test_no;
            end
            case (op)
                OP_WRITE: reg_access(addr, data, 1'b1);
                OP_READ: begin
                    reg_access(addr, 32'h0, 1'b0);
                    check_value("reg_rddata_o", expected, {24'h0, reg_rddata});
                end
                OP_FETCH:      fetch_word(addr, expected);
                OP_DISPLAY:    display_lookup(addr, expected);
                OP_FETCH_LOAD: fetch_under_load(addr, data, expected);
                OP_RESET: begin
                    reset_while_busy(addr);
                    check_value("fetch_ack_o", 32'h0, {31'h0, fetch_ack});
                    check_value("reg_rddata_o", expected, {24'h0, reg_rddata});
                end
                default: report_failure($sformatf("unknown operation %0h in test %0d",
                                                  op, test_no));
            endcase
        end
        if (num_records > 0) begin
            close_test(current_test);
        end

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Time budget grows with the number of records
    initial begin
        longint limit;
        wait (records_loaded);
        limit = longint'(num_records + 1) * CYCLES_PER_REC * CLK_PERIOD;
        #(limit);
        $display("ERROR: run did not finish within its budget of %0d ns", limit);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* dv/vid_fabric_chk.sv */
`timescale 1ns/1ps

// Fetch handshake rules, bound into the main RAM arbiter
module vid_fabric_chk (
    input logic clk,
    input logic reset,
    input logic reg_strobe_i,
    input logic fetch_strobe_i,
    input logic fetch_ack_i
);

    // No stale ack straight out of reset
    ack_after_reset: assert property (@(posedge clk) $fell(reset) |-> !fetch_ack_i)
        else $error("fetch ack high in the first cycle after reset");

    // Ack only after a granted cycle
    ack_needs_grant: assert property (@(posedge clk) disable iff (reset)
        fetch_ack_i |-> $past(fetch_strobe_i && !reg_strobe_i))
        else $error("fetch ack without a granted fetch cycle before it");

    no_ack_after_reg: assert property (@(posedge clk) disable iff (reset)
        $past(reg_strobe_i) |-> !fetch_ack_i)
        else $error("fetch ack in the cycle after a register strobe");

endmodule

bind membus_arbiter vid_fabric_chk fetch_chk (
    .clk            (clk),
    .reset          (reset),
    .reg_strobe_i   (rb.strobe),
    .fetch_strobe_i (fetch_strobe_i),
    .fetch_ack_i    (fetch_ack_o)
);

/* src/vid_fabric_top.sv */
`timescale 1ns/1ps

module vid_fabric_top (
    input  logic                                    clk,
    input  logic                                    reset,

    // Register bus
    input  vid_fabric_pkg::reg_addr_t               reg_addr_i,
    input  logic [vid_fabric_pkg::BYTE_W-1:0]       reg_wrdata_i,
    input  logic                                    reg_strobe_i,
    input  logic                                    reg_write_i,
    output logic [vid_fabric_pkg::BYTE_W-1:0]       reg_rddata_o,

    // Pixel fetch master
    input  logic [vid_fabric_pkg::FETCH_ADDR_W-1:0] fetch_addr_i,
    input  logic                                    fetch_strobe_i,
    output logic                                    fetch_ack_o,
    output vid_fabric_pkg::mem_word_t               fetch_rddata_o,

    // Display lookup
    input  logic [vid_fabric_pkg::BYTE_W-1:0]       display_idx_i,
    output vid_fabric_pkg::rgb_t                    display_rgb_o
);

    regbus_if mem_bus ();
    regbus_if pal_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // Register bus decode
    ////////////////////////////////////////////////////////////////////////////
    regbus_decoder decoder (
        .clk          (clk),
        .reset        (reset),
        .reg_addr_i   (reg_addr_i),
        .reg_wrdata_i (reg_wrdata_i),
        .reg_strobe_i (reg_strobe_i),
        .reg_write_i  (reg_write_i),
        .reg_rddata_o (reg_rddata_o),
        .mem          (mem_bus.host),
        .pal          (pal_bus.host)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Main RAM and palette
    ////////////////////////////////////////////////////////////////////////////
    membus_arbiter arbiter (
        .clk            (clk),
        .reset          (reset),
        .rb             (mem_bus.target),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_strobe_i (fetch_strobe_i),
        .fetch_ack_o    (fetch_ack_o),
        .fetch_rddata_o (fetch_rddata_o)
    );

    palette_bank palette (
        .clk           (clk),
        .rb            (pal_bus.target),
        .display_idx_i (display_idx_i),
        .display_rgb_o (display_rgb_o)
    );

endmodule

/* src/palette_bank.sv */
`timescale 1ns/1ps

// Two palette copies so readback never disturbs the display lookup
module palette_bank (
    input  logic                              clk,

    regbus_if.target                          rb,

    input  logic [vid_fabric_pkg::BYTE_W-1:0] display_idx_i,
    output vid_fabric_pkg::rgb_t              display_rgb_o
);

    localparam int IW = $clog2(vid_fabric_pkg::PAL_ENTRIES);

    logic [1:0]                 pal_we;
    logic [IW-1:0]              pal_idx;
    vid_fabric_pkg::pal_entry_t pal_wdata;
    vid_fabric_pkg::pal_entry_t disp_entry;
    vid_fabric_pkg::pal_entry_t rdbk_entry;
    logic                       hi_byte_r;

    // Entry index in bits 8..1, bit 0 picks the byte lane
    assign pal_idx   = rb.addr[IW:1];
    assign pal_wdata = {2{rb.wrdata}};
    assign pal_we    = (rb.strobe && rb.write) ? (rb.addr[0] ? 2'b10 : 2'b01) : 2'b00;

    lane_ram #(
        .word_t (vid_fabric_pkg::pal_entry_t),
        .DEPTH  (vid_fabric_pkg::PAL_ENTRIES)
    ) display_ram (
        .clk     (clk),
        .we_i    (pal_we),
        .waddr_i (pal_idx),
        .wdata_i (pal_wdata),
        .raddr_i (display_idx_i),
        .rdata_o (disp_entry)
    );

    lane_ram #(
        .word_t (vid_fabric_pkg::pal_entry_t),
        .DEPTH  (vid_fabric_pkg::PAL_ENTRIES)
    ) readback_ram (
        .clk     (clk),
        .we_i    (pal_we),
        .waddr_i (pal_idx),
        .wdata_i (pal_wdata),
        .raddr_i (pal_idx),
        .rdata_o (rdbk_entry)
    );

    always_ff @(posedge clk) begin
        hi_byte_r <= rb.addr[0];
    end

    assign rb.rddata     = hi_byte_r ? rdbk_entry[15:8] : rdbk_entry[7:0];
    assign display_rgb_o = disp_entry[11:0];

endmodule

/* src/membus_arbiter.sv */
`timescale 1ns/1ps

module membus_arbiter (
    input  logic                                    clk,
    input  logic                                    reset,

    regbus_if.target                                rb,

    input  logic [vid_fabric_pkg::FETCH_ADDR_W-1:0] fetch_addr_i,
    input  logic                                    fetch_strobe_i,
    output logic                                    fetch_ack_o,
    output vid_fabric_pkg::mem_word_t               fetch_rddata_o
);

    localparam int AW    = vid_fabric_pkg::MEM_AW;
    localparam int BW    = vid_fabric_pkg::BYTE_W;
    localparam int LANES = $bits(vid_fabric_pkg::mem_word_t) / BW;

    logic                      fetch_grant;
    logic                      reg_in_range;
    logic                      fetch_in_range;
    logic [AW-1:0]             ram_addr;
    logic [LANES-1:0]          ram_we;
    vid_fabric_pkg::mem_word_t ram_wdata;
    vid_fabric_pkg::mem_word_t ram_rdata;
    vid_fabric_pkg::mem_word_t word_q;
    logic                      fetch_ack_r;
    logic                      in_range_r;
    logic [$clog2(LANES)-1:0]  lane_r;

    ////////////////////////////////////////////////////////////////////////////
    // Arbitration
    ////////////////////////////////////////////////////////////////////////////
    // Register bus first, fetch only gets idle cycles
    assign fetch_grant = fetch_strobe_i && !rb.strobe;

    // Main RAM covers byte addresses 0x00000-0x1FFFF only
    assign reg_in_range   = (rb.addr[vid_fabric_pkg::REG_ADDR_W-1:AW+2] == '0);
    assign fetch_in_range = (fetch_addr_i[vid_fabric_pkg::FETCH_ADDR_W-1:AW] == '0);

    assign ram_addr  = rb.strobe ? rb.addr[AW+1:2] : fetch_addr_i[AW-1:0];
    assign ram_wdata = {LANES{rb.wrdata}};

    // Byte address to one-hot lane enable
    always_comb begin
        ram_we = '0;
        if (rb.strobe && rb.write && reg_in_range) begin
            ram_we[rb.addr[$clog2(LANES)-1:0]] = 1'b1;
        end
    end

    lane_ram #(
        .word_t (vid_fabric_pkg::mem_word_t),
        .DEPTH  (vid_fabric_pkg::MEM_WORDS)
    ) main_ram (
        .clk     (clk),
        .we_i    (ram_we),
        .waddr_i (ram_addr),
        .wdata_i (ram_wdata),
        .raddr_i (ram_addr),
        .rdata_o (ram_rdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Result stage
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fetch_ack_r <= 1'b0;
            in_range_r  <= 1'b0;
        end else begin
            fetch_ack_r <= fetch_grant;
            in_range_r  <= rb.strobe ? reg_in_range : fetch_in_range;
        end
    end

    always_ff @(posedge clk) begin
        lane_r <= rb.addr[$clog2(LANES)-1:0];
    end

    // Out-of-range accesses read as zero
    assign word_q = in_range_r ? ram_rdata : '0;

    assign rb.rddata      = word_q[lane_r*BW +: BW];
    assign fetch_ack_o    = fetch_ack_r;
    assign fetch_rddata_o = word_q;

endmodule

/* src/regbus_decoder.sv */
`timescale 1ns/1ps

module regbus_decoder (
    input  logic                              clk,
    input  logic                              reset,

    input  vid_fabric_pkg::reg_addr_t         reg_addr_i,
    input  logic [vid_fabric_pkg::BYTE_W-1:0] reg_wrdata_i,
    input  logic                              reg_strobe_i,
    input  logic                              reg_write_i,
    output logic [vid_fabric_pkg::BYTE_W-1:0] reg_rddata_o,

    regbus_if.host                            mem,
    regbus_if.host                            pal
);

    localparam int AW = vid_fabric_pkg::REG_ADDR_W;

    logic reg_space;
    logic mem_sel;
    logic pal_sel;
    logic mem_rd_r;
    logic pal_rd_r;

    ////////////////////////////////////////////////////////////////////////////
    // Region decode
    ////////////////////////////////////////////////////////////////////////////
    // 00000-EFFFF  memory space (main RAM below 0x20000)
    // F1000-F1FFF  palette
    // Other F-pages read as zero
    assign reg_space = (reg_addr_i[AW-1 -: 4] == vid_fabric_pkg::REG_PAGE_HI);
    assign mem_sel   = !reg_space;
    assign pal_sel   = reg_space && (reg_addr_i[AW-5 -: 4] == vid_fabric_pkg::PAGE_PALETTE);

    // Same address and data to both targets, strobe only to the selected one
    assign mem.addr   = reg_addr_i;
    assign mem.wrdata = reg_wrdata_i;
    assign mem.write  = reg_write_i;
    assign mem.strobe = reg_strobe_i && mem_sel;

    assign pal.addr   = reg_addr_i;
    assign pal.wrdata = reg_wrdata_i;
    assign pal.write  = reg_write_i;
    assign pal.strobe = reg_strobe_i && pal_sel;

    ////////////////////////////////////////////////////////////////////////////
    // Read data mux
    ////////////////////////////////////////////////////////////////////////////
    // Select delayed one cycle to line up with the registered target reads
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_rd_r <= 1'b0;
            pal_rd_r <= 1'b0;
        end else begin
            mem_rd_r <= mem.strobe && !reg_write_i;
            pal_rd_r <= pal.strobe && !reg_write_i;
        end
    end

    always_comb begin
        reg_rddata_o = '0;
        if (mem_rd_r) begin
            reg_rddata_o = mem.rddata;
        end else if (pal_rd_r) begin
            reg_rddata_o = pal.rddata;
        end
    end

endmodule

/* src/lane_ram.sv */
`timescale 1ns/1ps

// Synchronous RAM with per-byte-lane write enables and one registered read port
module lane_ram #(
    parameter type word_t = logic [31:0],
    parameter int  DEPTH  = 256
) (
    input  logic                                            clk,
    input  logic [$bits(word_t)/vid_fabric_pkg::BYTE_W-1:0] we_i,
    input  logic [$clog2(DEPTH)-1:0]                        waddr_i,
    input  word_t                                           wdata_i,
    input  logic [$clog2(DEPTH)-1:0]                        raddr_i,
    output word_t                                           rdata_o
);

    localparam int BW    = vid_fabric_pkg::BYTE_W;
    localparam int LANES = $bits(word_t) / BW;

    word_t mem [DEPTH];

    // Each enabled lane takes its byte of the write word
    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            if (we_i[l]) begin
                mem[waddr_i][l*BW +: BW] <= wdata_i[l*BW +: BW];
            end
        end
    end

    // Read before write on an address collision
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

/* src/regbus_if.sv */
`timescale 1ns/1ps

// One decoded target connection of the register bus
interface regbus_if;

    vid_fabric_pkg::reg_addr_t           addr;
    logic [vid_fabric_pkg::BYTE_W-1:0]   wrdata;
    logic                                write;
    // Already qualified with the target's region select
    logic                                strobe;
    // Valid in the cycle after a read strobe
    logic [vid_fabric_pkg::BYTE_W-1:0]   rddata;

    modport host (
        output addr,
        output wrdata,
        output write,
        output strobe,
        input  rddata
    );

    modport target (
        input  addr,
        input  wrdata,
        input  write,
        input  strobe,
        output rddata
    );

endinterface

/* src/vid_fabric_pkg.sv */
package vid_fabric_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int REG_ADDR_W   = 20;
    localparam int BYTE_W       = 8;
    // Word address from the pixel-fetch master
    localparam int FETCH_ADDR_W = 16;

    ////////////////////////////////////////////////////////////////////////////
    // Region codes
    ////////////////////////////////////////////////////////////////////////////
    // Address bits 19..16, anything else is memory space
    localparam logic [3:0] REG_PAGE_HI  = 4'hF;
    // Address bits 15..12 inside register space
    localparam logic [3:0] PAGE_PALETTE = 4'h1;

    ////////////////////////////////////////////////////////////////////////////
    // Memory sizes
    ////////////////////////////////////////////////////////////////////////////
    // 128 KiB of main RAM at 0x00000-0x1FFFF
    localparam int MEM_WORDS   = 32768;
    localparam int MEM_AW      = $clog2(MEM_WORDS);
    localparam int PAL_ENTRIES = 256;

    ////////////////////////////////////////////////////////////////////////////
    // Shared types
    ////////////////////////////////////////////////////////////////////////////
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Four byte lanes, lane 0 in bits 7..0
    typedef logic [31:0] mem_word_t;

    // 4-bit R, G, B in bits 11..0, upper nibble kept for readback only
    typedef logic [15:0] pal_entry_t;

    typedef logic [11:0] rgb_t;

endpackage
